/* Makefile */
# Verilator build and run for the instruction-fetch front end

VERILATOR ?= verilator
TOP       ?= tb_frontend
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
hw/frontend_pkg.sv
hw/instr_stream_if.sv
hw/fetch_unit.sv
hw/instr_buffer.sv
hw/decode_stage.sv
hw/frontend_top.sv
verif/frontend_assertions.sv
verif/tb_frontend.sv

/* hw/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                              aclk,
    input  logic                              rst_n,
    instr_stream_if.receiver                  dec_in,
    // trace port
    output logic                              dec_valid,
    input  logic                              dec_ready,
    output frontend_pkg::addr_t               dec_pc,
    output frontend_pkg::instr_kind_e         dec_kind,
    output logic [frontend_pkg::OPCODE_W-1:0] dec_opcode,
    output frontend_pkg::reg_idx_t            dec_rs,
    output frontend_pkg::reg_idx_t            dec_rt,
    output frontend_pkg::reg_idx_t            dec_rd,
    output frontend_pkg::word_t               dec_imm,
    // fetch redirect
    output logic                              redirect_valid,
    output frontend_pkg::addr_t               redirect_pc
);
    import frontend_pkg::*;

    instr_t      instr;
    addr_t       seq_pc;       // pc of the following slot
    word_t       jump_target;
    instr_kind_e kind_d;
    word_t       imm_d;
    logic        load;

    assign instr  = dec_in.instr;
    assign seq_pc = dec_in.pc + PC_STEP;

    // region of the next pc, word index, byte offset
    assign jump_target = {seq_pc[31:TARGET_W+2], instr.i[TARGET_W-1:0], 2'b00};

    always_comb begin
        if (instr.r.opcode == OP_SPECIAL) begin
            kind_d = KIND_R;
            imm_d  = {{(32-SHAMT_W){1'b0}}, instr.r.shamt};
        end else if (instr.i.opcode == OP_J || instr.i.opcode == OP_JAL) begin
            kind_d = KIND_J;
            imm_d  = jump_target;
        end else begin
            kind_d = KIND_I;
            imm_d  = {{(32-IMM_W){instr.i.imm[IMM_W-1]}}, instr.i.imm};
        end
    end

    // jump leaves on the trace port -> flush everything behind it
    assign redirect_valid = dec_valid && dec_ready && (dec_kind == KIND_J);
    assign redirect_pc    = dec_imm;

    assign dec_in.ready = (!dec_valid || dec_ready) && !redirect_valid;
    assign load         = dec_in.valid && dec_in.ready;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (load) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0; // drained
        end
    end

    // payload only moves on a load, so it holds under back-pressure
    always_ff @(posedge aclk) begin
        if (load) begin
            dec_pc     <= dec_in.pc;
            dec_kind   <= kind_d;
            dec_opcode <= instr.r.opcode;
            dec_rs     <= instr.i.rs;
            dec_rt     <= instr.i.rt;
            dec_rd     <= instr.r.rd;
            dec_imm    <= imm_d;
        end
    end

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit #(
    parameter frontend_pkg::addr_t reset_pc        = 32'hbfc0_0000,
    parameter int                  max_outstanding = 4
) (
    input  logic                aclk,
    input  logic                rst_n,
    // axi read address
    output logic                arvalid,
    input  logic                arready,
    output frontend_pkg::addr_t araddr,
    // axi read data
    input  logic                rvalid,
    output logic                rready,
    input  frontend_pkg::word_t rdata,
    // jump redirect from decode
    input  logic                redirect_valid,
    input  frontend_pkg::addr_t redirect_pc,
    instr_stream_if.sender      fetch_out
);
    import frontend_pkg::*;

    localparam int PTR_W = (max_outstanding > 1) ? $clog2(max_outstanding) : 1;
    localparam int CNT_W = $clog2(max_outstanding + 1);

    logic             started_q;     // first cycle after reset is idle
    addr_t            pc_q;          // next address to request
    logic [CNT_W-1:0] inflight_q;    // accepted addresses not yet answered
    logic [CNT_W-1:0] discard_q;     // stale responses still to drop
    logic [PTR_W-1:0] push_ptr_q;
    logic [PTR_W-1:0] pop_ptr_q;

    addr_t            pc_fifo [max_outstanding];

    logic             ar_fire;
    logic             r_fire;
    logic             discarding;
    logic             below_limit;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(max_outstanding - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign discarding  = (discard_q != '0);
    assign below_limit = (inflight_q < CNT_W'(max_outstanding));

    // address is pulled back while a redirect is in progress
    assign arvalid = started_q && below_limit && !redirect_valid;
    assign araddr  = pc_q;
    assign ar_fire = arvalid && arready;

    // stale words are drained at full rate, live ones wait on the buffer
    assign rready = discarding ? 1'b1 : fetch_out.ready;
    assign r_fire = rvalid && rready;

    // response passes straight through to the stream
    assign fetch_out.valid = rvalid && !discarding;
    assign fetch_out.pc    = pc_fifo[pop_ptr_q];
    assign fetch_out.instr = rdata;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            started_q <= 1'b0;
            pc_q      <= reset_pc;
        end else begin
            started_q <= 1'b1;
            if (redirect_valid) begin
                pc_q <= redirect_pc;
            end else if (ar_fire) begin
                pc_q <= pc_q + PC_STEP;
            end
        end
    end

    // outstanding and discard bookkeeping
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            inflight_q <= '0;
            discard_q  <= '0;
        end else begin
            inflight_q <= inflight_q + CNT_W'(ar_fire) - CNT_W'(r_fire);
            if (redirect_valid) begin
                // everything still in flight is younger than the jump
                discard_q <= inflight_q - CNT_W'(r_fire);
            end else if (r_fire && discarding) begin
                discard_q <= discard_q - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            push_ptr_q <= '0;
            pop_ptr_q  <= '0;
        end else begin
            if (ar_fire) begin
                push_ptr_q <= ptr_inc(push_ptr_q);
            end
            if (r_fire) begin
                pop_ptr_q <= ptr_inc(pop_ptr_q);
            end
        end
    end

    // pc of each request, popped in order as responses come back
    always_ff @(posedge aclk) begin
        if (ar_fire) begin
            pc_fifo[push_ptr_q] <= pc_q;
        end
    end

endmodule

/* hw/frontend_pkg.sv */
package frontend_pkg;

    // field widths of a mips instruction word
    localparam int OPCODE_W = 6;
    localparam int REG_W    = 5;
    localparam int SHAMT_W  = 5;
    localparam int FUNCT_W  = 6;
    localparam int IMM_W    = 16;
    localparam int TARGET_W = 26; // j / jal word index

    typedef logic [31:0]      addr_t;
    typedef logic [31:0]      word_t;
    typedef logic [REG_W-1:0] reg_idx_t;

    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        reg_idx_t            rs;
        reg_idx_t            rt;
        reg_idx_t            rd;
        logic [SHAMT_W-1:0]  shamt;
        logic [FUNCT_W-1:0]  funct;
    } r_fmt_t;

    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        reg_idx_t            rs;
        reg_idx_t            rt;
        logic [IMM_W-1:0]    imm;
    } i_fmt_t;

    // jump format overlaps the low bits of the immediate view
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    typedef enum logic [1:0] {
        KIND_R,
        KIND_I,
        KIND_J
    } instr_kind_e;

    localparam logic [OPCODE_W-1:0] OP_SPECIAL = 6'h00;
    localparam logic [OPCODE_W-1:0] OP_J       = 6'h02;
    localparam logic [OPCODE_W-1:0] OP_JAL     = 6'h03;

    localparam addr_t PC_STEP = 32'd4;

endpackage

/* hw/frontend_top.sv */
`timescale 1ns/100ps

module frontend_top #(
    parameter frontend_pkg::addr_t reset_pc        = 32'hbfc0_0000,
    parameter int                  max_outstanding = 4,
    parameter int                  buf_depth       = 4
) (
    input  logic                              aclk,
    input  logic                              rst_n,
    // axi read address channel
    output logic                              arvalid,
    input  logic                              arready,
    output frontend_pkg::addr_t               araddr,
    // axi read data channel
    input  logic                              rvalid,
    output logic                              rready,
    input  frontend_pkg::word_t               rdata,
    // decoded instruction trace
    output logic                              dec_valid,
    input  logic                              dec_ready,
    output frontend_pkg::addr_t               dec_pc,
    output frontend_pkg::instr_kind_e         dec_kind,
    output logic [frontend_pkg::OPCODE_W-1:0] dec_opcode,
    output frontend_pkg::reg_idx_t            dec_rs,
    output frontend_pkg::reg_idx_t            dec_rt,
    output frontend_pkg::reg_idx_t            dec_rd,
    output frontend_pkg::word_t               dec_imm
);
    import frontend_pkg::*;

    logic  redirect_valid;
    addr_t redirect_pc;

    instr_stream_if fetch_bus ();  // fetch -> buffer
    instr_stream_if dec_bus ();    // buffer -> decode

    fetch_unit #(
        .reset_pc        (reset_pc),
        .max_outstanding (max_outstanding)
    ) u_fetch_unit (
        .aclk            (aclk),
        .rst_n           (rst_n),
        .arvalid         (arvalid),
        .arready         (arready),
        .araddr          (araddr),
        .rvalid          (rvalid),
        .rready          (rready),
        .rdata           (rdata),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .fetch_out       (fetch_bus.sender)
    );

    instr_buffer #(
        .buf_depth       (buf_depth)
    ) u_instr_buffer (
        .aclk            (aclk),
        .rst_n           (rst_n),
        .redirect_valid  (redirect_valid),
        .buf_in          (fetch_bus.receiver),
        .buf_out         (dec_bus.sender)
    );

    decode_stage u_decode_stage (
        .aclk            (aclk),
        .rst_n           (rst_n),
        .dec_in          (dec_bus.receiver),
        .dec_valid       (dec_valid),
        .dec_ready       (dec_ready),
        .dec_pc          (dec_pc),
        .dec_kind        (dec_kind),
        .dec_opcode      (dec_opcode),
        .dec_rs          (dec_rs),
        .dec_rt          (dec_rt),
        .dec_rd          (dec_rd),
        .dec_imm         (dec_imm),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc)
    );

endmodule

/* hw/instr_buffer.sv */
`timescale 1ns/100ps

module instr_buffer #(
    parameter int buf_depth = 4
) (
    input  logic             aclk,
    input  logic             rst_n,
    input  logic             redirect_valid,
    instr_stream_if.receiver buf_in,
    instr_stream_if.sender   buf_out
);
    import frontend_pkg::*;

    localparam int PTR_W = $clog2(buf_depth);
    localparam int CNT_W = PTR_W + 1;

    addr_t            pc_mem   [buf_depth];
    word_t            word_mem [buf_depth];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;  // occupancy

    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full = (count_q == CNT_W'(buf_depth));

    assign buf_in.ready = !full;
    // writes during a redirect would be younger than the jump
    assign wr_en = buf_in.valid && buf_in.ready && !redirect_valid;

    assign buf_out.valid = (count_q != '0);
    assign buf_out.pc    = pc_mem[rd_ptr_q];
    assign buf_out.instr = word_mem[rd_ptr_q];
    assign rd_en         = buf_out.valid && buf_out.ready;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (redirect_valid) begin
            // flush
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // power of two depth wraps naturally
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            pc_mem[wr_ptr_q]   <= buf_in.pc;
            word_mem[wr_ptr_q] <= buf_in.instr;
        end
    end

endmodule

/* hw/instr_stream_if.sv */
`timescale 1ns/100ps

interface instr_stream_if;
    import frontend_pkg::*;

    logic  valid;
    logic  ready;
    addr_t pc;    // address the word was fetched from
    word_t instr;

    modport sender (
        output valid,
        output pc,
        output instr,
        input  ready
    );

    modport receiver (
        input  valid,
        input  pc,
        input  instr,
        output ready
    );

endinterface

/* verif/frontend_assertions.sv */
`timescale 1ns/100ps

module frontend_assertions #(
    parameter int max_outstanding = 4
) (
    input logic                              aclk,
    input logic                              rst_n,
    input logic                              arvalid,
    input logic                              arready,
    input frontend_pkg::addr_t               araddr,
    input logic                              rvalid,
    input logic                              rready,
    input logic                              dec_valid,
    input logic                              dec_ready,
    input frontend_pkg::addr_t               dec_pc,
    input frontend_pkg::instr_kind_e         dec_kind,
    input logic [frontend_pkg::OPCODE_W-1:0] dec_opcode,
    input frontend_pkg::reg_idx_t            dec_rs,
    input frontend_pkg::reg_idx_t            dec_rt,
    input frontend_pkg::reg_idx_t            dec_rd,
    input frontend_pkg::word_t               dec_imm
);
    int pending;        // accepted addresses not yet answered
    int fail_count = 0;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            pending <= 0;
        end else begin
            pending <= pending + int'(arvalid && arready) - int'(rvalid && rready);
        end
    end

    reset_idle: assert property (@(posedge aclk) !rst_n |=> !arvalid && !dec_valid)
        else begin
            fail_count++;
            $error("arvalid or dec_valid high during reset or right after it");
        end

    trace_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_pc) && $stable(dec_kind)
            && $stable(dec_opcode) && $stable(dec_rs) && $stable(dec_rt)
            && $stable(dec_rd) && $stable(dec_imm))
        else begin
            fail_count++;
            $error("trace output changed while stalled");
        end

    ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> $stable(araddr))
        else begin
            fail_count++;
            $error("araddr changed while the address was waiting");
        end

    ar_aligned: assert property (@(posedge aclk) rst_n |-> araddr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("araddr is not word aligned");
        end

    outstanding_limit: assert property (@(posedge aclk) disable iff (!rst_n)
        pending <= max_outstanding)
        else begin
            fail_count++;
            $error("too many reads in flight");
        end

endmodule

/* verif/tb_frontend.sv */
`timescale 1ns/100ps

module tb_frontend;
    import frontend_pkg::*;

    localparam addr_t reset_pc        = 32'hbfc0_0000;
    localparam int    max_outstanding = 4;
    localparam int    buf_depth       = 4;
    localparam int    n_instr         = 400;
    localparam int    max_cycles      = n_instr * 20;

    logic                aclk;
    logic                rst_n;
    logic                arvalid;
    logic                arready;
    addr_t               araddr;
    logic                rvalid;
    logic                rready;
    word_t               rdata;
    logic                dec_valid;
    logic                dec_ready;
    addr_t               dec_pc;
    instr_kind_e         dec_kind;
    logic [OPCODE_W-1:0] dec_opcode;
    reg_idx_t            dec_rs;
    reg_idx_t            dec_rt;
    reg_idx_t            dec_rd;
    word_t               dec_imm;

    word_t  prog_mem [256];   // indexed by address bits 9:2
    addr_t  addr_q [$];       // accepted addresses, answered in order
    logic   r_taken;
    integer seed;
    int     err_count;
    int     n_decoded;
    int     cycles;
    addr_t  exp_pc;

    frontend_top #(
        .reset_pc        (reset_pc),
        .max_outstanding (max_outstanding),
        .buf_depth       (buf_depth)
    ) u_frontend_top (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready),
        .dec_pc     (dec_pc),
        .dec_kind   (dec_kind),
        .dec_opcode (dec_opcode),
        .dec_rs     (dec_rs),
        .dec_rt     (dec_rt),
        .dec_rd     (dec_rd),
        .dec_imm    (dec_imm)
    );

    bind frontend_top frontend_assertions #(
        .max_outstanding (max_outstanding)
    ) u_frontend_assertions (
        .aclk (aclk), .rst_n (rst_n),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready),
        .dec_valid (dec_valid), .dec_ready (dec_ready), .dec_pc (dec_pc),
        .dec_kind (dec_kind), .dec_opcode (dec_opcode), .dec_rs (dec_rs),
        .dec_rt (dec_rt), .dec_rd (dec_rd), .dec_imm (dec_imm)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // random words without jumps, then a chain of eight jump slots
    task automatic fill_program();
        word_t w;
        int    i;
        int    k;
        int    slot;
        int    target;
        addr_t target_pc;
        for (i = 0; i < 256; i++) begin
            w = $random(seed);
            if (w[31:27] == 5'b00001) begin
                w[31] = 1'b1; // turns j/jal into a load
            end
            prog_mem[i] = w;
        end
        for (k = 0; k < 8; k++) begin
            slot      = 20 + 30 * k;
            target    = (k == 7) ? 3 : slot + 10; // last slot loops back
            target_pc = reset_pc + addr_t'(target * 4);
            prog_mem[slot] = {((k % 2) == 0) ? OP_J : OP_JAL, target_pc[27:2]};
        end
    endtask

    function automatic void expected_decode(input addr_t pc, input word_t w,
                                            output instr_kind_e kind, output word_t imm);
        addr_t next_pc;
        next_pc = pc + 32'd4;
        if (w[31:26] == OP_SPECIAL) begin
            kind = KIND_R;
            imm  = {27'd0, w[10:6]};                   // shamt
        end else if (w[31:26] == OP_J || w[31:26] == OP_JAL) begin
            kind = KIND_J;
            imm  = {next_pc[31:28], w[25:0], 2'b00};
        end else begin
            kind = KIND_I;
            imm  = {{16{w[15]}}, w[15:0]};
        end
    endfunction

    task automatic check_field(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            err_count++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_trace();
        word_t       w;
        instr_kind_e kind;
        word_t       imm;
        w = prog_mem[dec_pc[9:2]];
        expected_decode(dec_pc, w, kind, imm);
        check_field("dec_pc", dec_pc, exp_pc);
        check_field("dec_kind", 32'(dec_kind), 32'(kind));
        check_field("dec_opcode", 32'(dec_opcode), 32'(w[31:26]));
        check_field("dec_rs", 32'(dec_rs), 32'(w[25:21]));
        check_field("dec_rt", 32'(dec_rt), 32'(w[20:16]));
        check_field("dec_rd", 32'(dec_rd), 32'(w[15:11]));
        check_field("dec_imm", dec_imm, imm);
        exp_pc = (kind == KIND_J) ? imm : dec_pc + 32'd4;
        n_decoded++;
    endtask

    // handshakes seen just before the edge
    always @(posedge aclk) begin
        if (rst_n) begin
            if (arvalid && arready) begin
                addr_q.push_back(araddr);
            end
            if (rvalid && rready) begin
                void'(addr_q.pop_front());
                r_taken = 1'b1;
            end
            if (dec_valid && dec_ready) begin
                check_trace();
            end
        end
    end

    // slave and trace sink, with random gaps
    always @(negedge aclk) begin
        arready   = ($random(seed) & 3) != 0;
        dec_ready = ($random(seed) & 3) != 0;
        if (!rvalid || r_taken) begin
            rvalid = (addr_q.size() != 0) && (($random(seed) & 3) != 0);
        end
        if (rvalid) begin
            rdata = prog_mem[addr_q[0][9:2]];
        end
        r_taken = 1'b0;
    end

    initial begin
        rst_n     = 1'b0;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        dec_ready = 1'b0;
        r_taken   = 1'b0;
        err_count = 0;
        n_decoded = 0;
        cycles    = 0;
        exp_pc    = reset_pc;
        seed      = 32'he68d_3ece;
        fill_program();
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        while (n_decoded < n_instr && cycles < max_cycles) begin
            @(negedge aclk);
            cycles++;
        end
        if (n_decoded < n_instr) begin
            $display("timeout: %0d of %0d instructions decoded in %0d cycles",
                     n_decoded, n_instr, cycles);
        end
        $display("errors: %0d mismatches, %0d assertion failures, %0d instructions checked",
                 err_count, u_frontend_top.u_frontend_assertions.fail_count, n_decoded);
        if (err_count == 0 && u_frontend_top.u_frontend_assertions.fail_count == 0
                && n_decoded >= n_instr) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
